// ==== common/dvs_hssl_consts.svh ====
// sizes and APB register map of the event path, `include wherever a size or index is needed
`ifndef DVS_HSSL_CONSTS_SVH
`define DVS_HSSL_CONSTS_SVH

// ----------------------------------------------------------------------
// datapath sizes
// ----------------------------------------------------------------------
`define DVS_NUM_CHANNELS   8
`define DVS_NUM_ENTRIES    16
`define DVS_KEY_BITS       32
// must cover DVS_NUM_CHANNELS
`define DVS_ROUTE_BITS     3
`define DVS_HDR_BITS       8
`define DVS_APB_ADDR_BITS  8

// ----------------------------------------------------------------------
// register map, in 32-bit word indices
// ----------------------------------------------------------------------
`define DVS_REG_CTRL       0
`define DVS_REG_KEY_BASE   16
`define DVS_REG_MASK_BASE  32
`define DVS_REG_ROUTE_BASE 48

// multicast header, parity bit 0 left clear
`define DVS_HDR_MC         8'h00

`endif

// ==== common/dvs_hssl_pkg.sv ====
// types shared by the register bank, assembler, router and testbench, used by scoped name
`include "dvs_hssl_consts.svh"

package dvs_hssl_pkg;

  // plain vectors
  typedef logic [`DVS_KEY_BITS-1:0]      key_t;
  typedef logic [`DVS_ROUTE_BITS-1:0]    route_t;
  // APB data bus is fixed at 32 bits
  typedef logic [31:0]                   reg_word_t;
  typedef logic [`DVS_APB_ADDR_BITS-1:0] apb_addr_t;

  // multicast packet, key in the upper bits
  // header bit 0 makes all 40 bits odd parity
  typedef struct packed {
    key_t                     key;
    logic [`DVS_HDR_BITS-1:0] header;
  } pkt_t;

  // one routing table entry
  typedef struct packed {
    key_t   key;
    key_t   mask;
    route_t route;
  } route_entry_t;

  typedef route_entry_t [`DVS_NUM_ENTRIES-1:0] route_table_t;

  // APB request, driven by the master
  typedef struct packed {
    logic      sel;
    logic      enable;
    logic      write;
    apb_addr_t addr;
    reg_word_t wdata;
  } apb_req_t;

  // APB response, driven by the slave
  typedef struct packed {
    reg_word_t rdata;
    logic      ready;
    logic      slverr;
  } apb_rsp_t;

  // one packet per transmit channel
  typedef pkt_t [`DVS_NUM_CHANNELS-1:0] pkt_vec_t;

endpackage

// ==== reg_bank/hssl_reg_bank.sv ====
// APB slave with the stop bit and the key/mask/route table, feeds the packet router
`include "dvs_hssl_consts.svh"

module hssl_reg_bank
(
  input  logic                       pl_clk0_buf_int,
  input  logic                       rst_n,

  input  dvs_hssl_pkg::apb_req_t     apb_req,
  output dvs_hssl_pkg::apb_rsp_t     apb_rsp,

  output dvs_hssl_pkg::route_table_t route_table,
  output logic                       stop
);

  localparam int ENT_BITS = $clog2(`DVS_NUM_ENTRIES);

  // ----------------------------------------------------------------------
  // address decode
  // ----------------------------------------------------------------------
  // word index, byte lanes dropped
  int                         word_idx;
  logic [ENT_BITS-1:0]        ent;
  logic                       ctrl_sel;
  logic                       key_sel;
  logic                       mask_sel;
  logic                       route_sel;
  logic                       mapped;
  logic                       access;
  logic                       wr_en;

  // register state
  dvs_hssl_pkg::route_table_t table_q;
  logic                       stop_q;
  dvs_hssl_pkg::reg_word_t    rdata;

  assign word_idx  = int'(apb_req.addr[`DVS_APB_ADDR_BITS-1:2]);
  // table bases are 16-word aligned
  // so the low bits give the entry
  assign ent       = word_idx[ENT_BITS-1:0];

  assign ctrl_sel  = (word_idx == `DVS_REG_CTRL);
  assign key_sel   = (word_idx >= `DVS_REG_KEY_BASE) &&
                     (word_idx <  `DVS_REG_KEY_BASE + `DVS_NUM_ENTRIES);
  assign mask_sel  = (word_idx >= `DVS_REG_MASK_BASE) &&
                     (word_idx <  `DVS_REG_MASK_BASE + `DVS_NUM_ENTRIES);
  assign route_sel = (word_idx >= `DVS_REG_ROUTE_BASE) &&
                     (word_idx <  `DVS_REG_ROUTE_BASE + `DVS_NUM_ENTRIES);
  assign mapped    = ctrl_sel | key_sel | mask_sel | route_sel;

  // access phase of a transfer
  assign access    = apb_req.sel & apb_req.enable;
  // unmapped writes fall through here
  assign wr_en     = access & apb_req.write & mapped;

  // ----------------------------------------------------------------------
  // register writes
  // ----------------------------------------------------------------------
  // table clears to zero, every key then hits entry 0
  always_ff @(posedge pl_clk0_buf_int or negedge rst_n)
  begin
    if (!rst_n)
    begin
      table_q <= '0;
      stop_q  <= 1'b0;
    end
    else if (wr_en)
    begin
      if (ctrl_sel)
        stop_q <= apb_req.wdata[0];
      if (key_sel)
        table_q[ent].key <= apb_req.wdata;
      if (mask_sel)
        table_q[ent].mask <= apb_req.wdata;
      // only the channel index bits are kept
      if (route_sel)
        table_q[ent].route <= apb_req.wdata[`DVS_ROUTE_BITS-1:0];
    end
  end

  // ----------------------------------------------------------------------
  // read mux
  // ----------------------------------------------------------------------
  always_comb
  begin
    rdata = '0;
    if (ctrl_sel)
      rdata[0] = stop_q;
    else if (key_sel)
      rdata = table_q[ent].key;
    else if (mask_sel)
      rdata = table_q[ent].mask;
    else if (route_sel)
      rdata[`DVS_ROUTE_BITS-1:0] = table_q[ent].route;
  end

  // no wait states
  // error flagged only in the access phase
  assign apb_rsp = '{rdata: rdata, ready: 1'b1, slverr: access & ~mapped};

  assign route_table = table_q;
  assign stop        = stop_q;

endmodule

// ==== pkt_path/pkt_assembler.sv ====
// turns each processor event into a parity-protected multicast packet for the router
`include "dvs_hssl_consts.svh"

module pkt_assembler
(
  input  logic                   pl_clk0_buf_int,
  input  logic                   rst_n,

  // events in
  input  dvs_hssl_pkg::key_t     evt_data,
  input  logic                   evt_vld,
  output logic                   evt_rdy,

  // packet out
  output dvs_hssl_pkg::pkt_t     pkt,
  output logic                   pkt_vld,
  input  logic                   pkt_rdy
);

  // ----------------------------------------------------------------------
  // packet build
  // ----------------------------------------------------------------------
  dvs_hssl_pkg::pkt_t new_pkt;
  logic               evt_take;

  // one-entry output buffer
  dvs_hssl_pkg::pkt_t pkt_q;
  logic               vld_q;

  // fixed header bits, then bit 0 so the
  // whole packet carries odd parity
  always_comb
  begin
    new_pkt.key       = evt_data;
    new_pkt.header    = `DVS_HDR_MC;
    new_pkt.header[0] = ~(^evt_data ^ ^new_pkt.header[`DVS_HDR_BITS-1:1]);
  end

  // ----------------------------------------------------------------------
  // output buffer
  // ----------------------------------------------------------------------
  // free, or emptied by the router this cycle
  assign evt_rdy  = ~vld_q | pkt_rdy;
  assign evt_take = evt_vld & evt_rdy;

  always_ff @(posedge pl_clk0_buf_int or negedge rst_n)
  begin
    if (!rst_n)
      vld_q <= 1'b0;
    else if (evt_take)
      vld_q <= 1'b1;
    else if (pkt_rdy)
      vld_q <= 1'b0;
  end

  // payload only, qualified by vld_q
  always_ff @(posedge pl_clk0_buf_int)
  begin
    if (evt_take)
      pkt_q <= new_pkt;
  end

  assign pkt     = pkt_q;
  assign pkt_vld = vld_q;

endmodule

// ==== pkt_path/pkt_router.sv ====
// first-match key/mask router, one registered output slot per transmit channel
`include "dvs_hssl_consts.svh"

module pkt_router
(
  input  logic                         pl_clk0_buf_int,
  input  logic                         rst_n,

  // routing table and stop from the register bank
  input  dvs_hssl_pkg::route_table_t   route_table,
  input  logic                         stop,

  // packet in
  input  dvs_hssl_pkg::pkt_t           pkt,
  input  logic                         pkt_vld,
  output logic                         pkt_rdy,

  // transmit channels
  output dvs_hssl_pkg::pkt_vec_t       tx_pkt,
  output logic [`DVS_NUM_CHANNELS-1:0] tx_vld,
  input  logic [`DVS_NUM_CHANNELS-1:0] tx_rdy
);

  // ----------------------------------------------------------------------
  // internal signals
  // ----------------------------------------------------------------------
  // lookup result
  logic                         hit;
  dvs_hssl_pkg::route_t         route;

  // per-channel slot state
  logic [`DVS_NUM_CHANNELS-1:0] slot_free;
  logic [`DVS_NUM_CHANNELS-1:0] load;
  logic [`DVS_NUM_CHANNELS-1:0] vld_q;
  dvs_hssl_pkg::pkt_vec_t       pkt_q;

  // packet accepted and going to a channel
  logic                         take;

  // ----------------------------------------------------------------------
  // table lookup
  // ----------------------------------------------------------------------
  // scan from the top down, so the lowest
  // matching index is the one that sticks
  always_comb
  begin
    hit   = 1'b0;
    route = '0;
    for (int i = `DVS_NUM_ENTRIES - 1; i >= 0; i--)
    begin
      if ((pkt.key & route_table[i].mask) == route_table[i].key)
      begin
        hit   = 1'b1;
        route = route_table[i].route;
      end
    end
  end

  // ----------------------------------------------------------------------
  // accept
  // ----------------------------------------------------------------------
  // slot empty, or drained this same cycle
  assign slot_free = ~vld_q | tx_rdy;

  // misses are dropped, so they only wait for stop
  assign pkt_rdy = ~stop & (~hit | slot_free[route]);
  assign take    = pkt_vld & pkt_rdy & hit;

  // ----------------------------------------------------------------------
  // output slots
  // ----------------------------------------------------------------------
  for (genvar ch = 0; ch < `DVS_NUM_CHANNELS; ch++)
  begin : g_slot
    assign load[ch] = take & (route == dvs_hssl_pkg::route_t'(ch));

    // valid held until the channel takes it
    always_ff @(posedge pl_clk0_buf_int or negedge rst_n)
    begin
      if (!rst_n)
        vld_q[ch] <= 1'b0;
      else if (load[ch])
        vld_q[ch] <= 1'b1;
      else if (tx_rdy[ch])
        vld_q[ch] <= 1'b0;
    end

    // stable while valid and not ready
    always_ff @(posedge pl_clk0_buf_int)
    begin
      if (load[ch])
        pkt_q[ch] <= pkt;
    end
  end

  assign tx_pkt = pkt_q;
  assign tx_vld = vld_q;

endmodule

// ==== src/dvs_hssl_top.sv ====
// top level of the event path, ties register bank, packet assembler and router together
`include "dvs_hssl_consts.svh"

module dvs_hssl_top
(
  input  logic                           pl_clk0_buf_int,
  input  logic                           rst_n,

  // register access
  input  dvs_hssl_pkg::apb_req_t         apb_req,
  output dvs_hssl_pkg::apb_rsp_t         apb_rsp,

  // events from the processor side
  input  dvs_hssl_pkg::key_t             evt_data,
  input  logic                           evt_vld,
  output logic                           evt_rdy,

  // transmit channels
  output dvs_hssl_pkg::pkt_vec_t         tx_pkt,
  output logic [`DVS_NUM_CHANNELS-1:0]   tx_vld,
  input  logic [`DVS_NUM_CHANNELS-1:0]   tx_rdy
);

  // ----------------------------------------------------------------------
  // internal signals
  // ----------------------------------------------------------------------
  // table and stop bit from the register bank
  dvs_hssl_pkg::route_table_t route_table;
  logic                       stop;

  // assembler to router
  dvs_hssl_pkg::pkt_t         pkt;
  logic                       pkt_vld;
  logic                       pkt_rdy;

  // ----------------------------------------------------------------------
  // register bank
  // ----------------------------------------------------------------------
  hssl_reg_bank u_reg_bank
  (
    .pl_clk0_buf_int (pl_clk0_buf_int),
    .rst_n           (rst_n),
    .apb_req         (apb_req),
    .apb_rsp         (apb_rsp),
    .route_table     (route_table),
    .stop            (stop)
  );

  // ----------------------------------------------------------------------
  // event to packet
  // ----------------------------------------------------------------------
  pkt_assembler u_pkt_assembler
  (
    .pl_clk0_buf_int (pl_clk0_buf_int),
    .rst_n           (rst_n),
    .evt_data        (evt_data),
    .evt_vld         (evt_vld),
    .evt_rdy         (evt_rdy),
    .pkt             (pkt),
    .pkt_vld         (pkt_vld),
    .pkt_rdy         (pkt_rdy)
  );

  // ----------------------------------------------------------------------
  // packet to channel
  // ----------------------------------------------------------------------
  pkt_router u_pkt_router
  (
    .pl_clk0_buf_int (pl_clk0_buf_int),
    .rst_n           (rst_n),
    .route_table     (route_table),
    .stop            (stop),
    .pkt             (pkt),
    .pkt_vld         (pkt_vld),
    .pkt_rdy         (pkt_rdy),
    .tx_pkt          (tx_pkt),
    .tx_vld          (tx_vld),
    .tx_rdy          (tx_rdy)
  );

endmodule

// ==== verification/tb_dvs_hssl_tasks.svh ====
// testbench tasks for the event path, `include inside the testbench top after its signals

// ----------------------------------------------------------------------
// compare tasks
// ----------------------------------------------------------------------
task automatic check_word(input dvs_hssl_pkg::reg_word_t got,
                          input dvs_hssl_pkg::reg_word_t exp, input string what);
  if (got !== exp)
  begin
    $display("[FAIL] %0t: %s, got %h expected %h", $time, what, got, exp);
    err_value++;
  end
endtask

task automatic check_pkt(input dvs_hssl_pkg::pkt_t got,
                         input dvs_hssl_pkg::pkt_t exp, input string what);
  if (got !== exp)
  begin
    $display("[FAIL] %0t: %s, got key %h hdr %h expected key %h hdr %h",
             $time, what, got.key, got.header, exp.key, exp.header);
    err_value++;
  end
endtask

task automatic check_flag(input logic got, input logic exp, input string what);
  if (got !== exp)
  begin
    $display("[FAIL] %0t: %s, got %b expected %b", $time, what, got, exp);
    err_value++;
  end
endtask

// ----------------------------------------------------------------------
// stimulus and reference model
// ----------------------------------------------------------------------
// galois LFSR, x^32 + x^22 + x^2 + x + 1, one step per bit
function automatic dvs_hssl_pkg::key_t rand_bits(input int n);
  dvs_hssl_pkg::key_t r;
  r = '0;
  for (int i = 0; i < n; i++)
  begin
    r = {r[`DVS_KEY_BITS-2:0], lfsr_state[0]};
    lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
  end
  return r;
endfunction

// header bit 0 set when the rest has even parity
function automatic dvs_hssl_pkg::pkt_t make_pkt(input dvs_hssl_pkg::key_t key);
  dvs_hssl_pkg::pkt_t p;
  p.key    = key;
  p.header = `DVS_HDR_MC;
  if (^p == 1'b0)
    p.header[0] = 1'b1;
  return p;
endfunction

// lowest matching entry wins, -1 for a drop
function automatic int route_of(input dvs_hssl_pkg::key_t key);
  for (int i = 0; i < `DVS_NUM_ENTRIES; i++)
    if ((key & tbl_mask[i]) == tbl_key[i])
      return int'(tbl_route[i]);
  return -1;
endfunction

function automatic int pending_count();
  int n;
  n = 0;
  for (int ch = 0; ch < NUM_CH; ch++)
    n += exp_q[ch].size();
  return n;
endfunction

// ----------------------------------------------------------------------
// bus access, all tasks start and end 10 ns after a rising edge
// ----------------------------------------------------------------------
task automatic apb_xfer(input logic wr, input int idx, input dvs_hssl_pkg::reg_word_t wdata,
                        output dvs_hssl_pkg::reg_word_t rdata, output logic err);
  // setup cycle
  apb_req.sel    = 1'b1;
  apb_req.enable = 1'b0;
  apb_req.write  = wr;
  apb_req.addr   = dvs_hssl_pkg::apb_addr_t'(idx * 4);
  apb_req.wdata  = wdata;
  @(posedge pl_clk0_buf_int);
  #10;
  // access cycle, response sampled mid-cycle
  apb_req.enable = 1'b1;
  @(negedge pl_clk0_buf_int);
  rdata = apb_rsp.rdata;
  err   = apb_rsp.slverr;
  // no wait states expected
  check_flag(apb_rsp.ready, 1'b1, "APB ready in access cycle");
  @(posedge pl_clk0_buf_int);
  #10;
  apb_req = '0;
endtask

task automatic apb_write(input int idx, input dvs_hssl_pkg::reg_word_t data, output logic err);
  dvs_hssl_pkg::reg_word_t unused;
  apb_xfer(1'b1, idx, data, unused, err);
endtask

task automatic apb_read(input int idx, output dvs_hssl_pkg::reg_word_t data, output logic err);
  apb_xfer(1'b0, idx, '0, data, err);
endtask

// programs one table entry and the model copy
task automatic set_entry(input int i, input dvs_hssl_pkg::key_t key,
                         input dvs_hssl_pkg::key_t mask, input dvs_hssl_pkg::route_t route);
  logic err;
  apb_write(`DVS_REG_KEY_BASE + i, key, err);
  apb_write(`DVS_REG_MASK_BASE + i, mask, err);
  apb_write(`DVS_REG_ROUTE_BASE + i, dvs_hssl_pkg::reg_word_t'(route), err);
  tbl_key[i]   = key;
  tbl_mask[i]  = mask;
  tbl_route[i] = route;
endtask

// ----------------------------------------------------------------------
// events
// ----------------------------------------------------------------------
task automatic expect_event(input dvs_hssl_pkg::key_t key);
  int ch;
  ch = route_of(key);
  if (ch >= 0)
    exp_q[ch].push_back(make_pkt(key));
endtask

// evt_rdy is stable at the falling edge
task automatic wait_accept();
  @(negedge pl_clk0_buf_int);
  while (!evt_rdy)
    @(negedge pl_clk0_buf_int);
  @(posedge pl_clk0_buf_int);
  #10;
  evt_vld = 1'b0;
endtask

task automatic send_event(input dvs_hssl_pkg::key_t key);
  expect_event(key);
  evt_data = key;
  evt_vld  = 1'b1;
  wait_accept();
endtask

task automatic drain();
  while (pending_count() != 0)
  begin
    @(posedge pl_clk0_buf_int);
    #10;
  end
endtask

// ==== verification/tb_dvs_hssl_top.sv ====
// testbench top of the event path, stands in for the processor on APB and events
`include "dvs_hssl_consts.svh"

module tb_dvs_hssl_top;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_CH     = `DVS_NUM_CHANNELS;
  // far past the full test sequence
  localparam int MAX_CYCLES = 4000;

  // ----------------------------------------------------------------------
  // DUT signals
  // ----------------------------------------------------------------------
  logic                    pl_clk0_buf_int = 1'b0;
  logic                    rst_n;
  dvs_hssl_pkg::apb_req_t  apb_req;
  dvs_hssl_pkg::apb_rsp_t  apb_rsp;
  dvs_hssl_pkg::key_t      evt_data;
  logic                    evt_vld;
  logic                    evt_rdy;
  dvs_hssl_pkg::pkt_vec_t  tx_pkt;
  logic [NUM_CH-1:0]       tx_vld;
  logic [NUM_CH-1:0]       tx_rdy;

  // model table copy and expected packets per channel
  dvs_hssl_pkg::key_t      tbl_key   [`DVS_NUM_ENTRIES];
  dvs_hssl_pkg::key_t      tbl_mask  [`DVS_NUM_ENTRIES];
  dvs_hssl_pkg::route_t    tbl_route [`DVS_NUM_ENTRIES];
  dvs_hssl_pkg::pkt_t      exp_q     [NUM_CH][$];
  // last stalled packet per channel
  dvs_hssl_pkg::pkt_t      held_pkt  [NUM_CH];
  logic [NUM_CH-1:0]       held_vld;
  logic [31:0]             lfsr_state;
  int                      err_value;
  int                      err_other;
  int                      cycles;

  `include "tb_dvs_hssl_tasks.svh"

  dvs_hssl_top u_dvs_hssl_top
  (
    .pl_clk0_buf_int (pl_clk0_buf_int),
    .rst_n           (rst_n),
    .apb_req         (apb_req),
    .apb_rsp         (apb_rsp),
    .evt_data        (evt_data),
    .evt_vld         (evt_vld),
    .evt_rdy         (evt_rdy),
    .tx_pkt          (tx_pkt),
    .tx_vld          (tx_vld),
    .tx_rdy          (tx_rdy)
  );

  // 100 ns period
  always #50 pl_clk0_buf_int = ~pl_clk0_buf_int;

  always @(posedge pl_clk0_buf_int)
  begin
    cycles++;
    if (cycles == MAX_CYCLES)
    begin
      $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
      $display("TEST FAIL");
      $finish;
    end
  end

  // ----------------------------------------------------------------------
  // channel monitor, mid-cycle so all outputs are settled
  // ----------------------------------------------------------------------
  always @(negedge pl_clk0_buf_int)
  begin
    for (int ch = 0; ch < NUM_CH; ch++)
    begin
      // stalled packet must not move
      if (tx_vld[ch] && held_vld[ch])
        check_pkt(tx_pkt[ch], held_pkt[ch], "stalled channel packet changed");
      held_vld[ch] = tx_vld[ch] && !tx_rdy[ch];
      held_pkt[ch] = tx_pkt[ch];
      if (tx_vld[ch] && tx_rdy[ch])
      begin
        if (exp_q[ch].size() == 0)
        begin
          $display("unexpected packet on channel %0d at %0t", ch, $time);
          err_other++;
        end
        else
          check_pkt(tx_pkt[ch], exp_q[ch].pop_front(), "channel packet");
      end
    end
  end

  // ----------------------------------------------------------------------
  // tests
  // ----------------------------------------------------------------------
  task automatic test_default_route();
    for (int n = 0; n < 20; n++)
      send_event(rand_bits(32));
    drain();
  endtask

  task automatic test_registers();
    int                      base [3] = '{`DVS_REG_KEY_BASE, `DVS_REG_MASK_BASE,
                                          `DVS_REG_ROUTE_BASE};
    dvs_hssl_pkg::reg_word_t wd;
    dvs_hssl_pkg::reg_word_t rd;
    dvs_hssl_pkg::reg_word_t keep;
    logic                    err;
    apb_write(`DVS_REG_CTRL, 32'h1, err);
    apb_read(`DVS_REG_CTRL, rd, err);
    check_word(rd, 32'h1, "ctrl readback");
    apb_write(`DVS_REG_CTRL, 32'h0, err);
    for (int i = 0; i < `DVS_NUM_ENTRIES; i++)
      for (int r = 0; r < 3; r++)
      begin
        wd = rand_bits(32);
        apb_write(base[r] + i, wd, err);
        apb_read(base[r] + i, rd, err);
        check_flag(err, 1'b0, "slverr on mapped register");
        // first key, neighbour of the unmapped gap
        if (r == 0 && i == 0)
          keep = wd;
        // route keeps its low bits only
        if (r == 2)
          wd = wd & dvs_hssl_pkg::reg_word_t'((1 << `DVS_ROUTE_BITS) - 1);
        check_word(rd, wd, "table readback");
      end
    // unmapped indices in the gap below the key table
    apb_read(5, rd, err);
    check_flag(err, 1'b1, "slverr on read of index 5");
    check_word(rd, '0, "read data of index 5");
    apb_write(5, 32'hFFFF_FFFF, err);
    check_flag(err, 1'b1, "slverr on write of index 5");
    apb_read(`DVS_REG_CTRL, rd, err);
    check_word(rd, '0, "ctrl after unmapped write");
    apb_write(15, 32'hFFFF_FFFF, err);
    check_flag(err, 1'b1, "slverr on write of index 15");
    apb_read(15, rd, err);
    check_flag(err, 1'b1, "slverr on read of index 15");
    check_word(rd, '0, "read data of index 15");
    apb_read(`DVS_REG_KEY_BASE, rd, err);
    check_word(rd, keep, "first key after unmapped write");
  endtask

  // nested low-bit masks, keys with bit 31 clear miss
  task automatic test_programmed();
    dvs_hssl_pkg::key_t mask;
    for (int i = 0; i < `DVS_NUM_ENTRIES; i++)
    begin
      mask = 32'h8000_0000 | (32'h0000_000F >> (i / 4));
      set_entry(i, (rand_bits(32) & mask) | 32'h8000_0000, mask,
                dvs_hssl_pkg::route_t'(rand_bits(`DVS_ROUTE_BITS)));
    end
    for (int n = 0; n < 60; n++)
      send_event(rand_bits(32));
    drain();
  endtask

  task automatic test_backpressure();
    dvs_hssl_pkg::key_t key;
    // every key to channel 5
    set_entry(0, '0, '0, 3'd5);
    tx_rdy[5] = 1'b0;
    // one in the slot, one in the assembler
    send_event(rand_bits(32));
    send_event(rand_bits(32));
    key = rand_bits(32);
    expect_event(key);
    evt_data = key;
    evt_vld  = 1'b1;
    repeat (6)
    begin
      @(negedge pl_clk0_buf_int);
      check_flag(evt_rdy, 1'b0, "evt_rdy with channel stalled");
    end
    @(posedge pl_clk0_buf_int);
    #10;
    tx_rdy[5] = 1'b1;
    wait_accept();
    for (int n = 0; n < 5; n++)
      send_event(rand_bits(32));
    drain();
  endtask

  task automatic test_stop();
    logic err;
    apb_write(`DVS_REG_CTRL, 32'h1, err);
    send_event(rand_bits(32));
    repeat (8)
    begin
      @(negedge pl_clk0_buf_int);
      check_flag(|tx_vld, 1'b0, "tx_vld while stopped");
    end
    check_flag(evt_rdy, 1'b0, "evt_rdy while stopped");
    @(posedge pl_clk0_buf_int);
    #10;
    apb_write(`DVS_REG_CTRL, 32'h0, err);
    for (int n = 0; n < 4; n++)
      send_event(rand_bits(32));
    drain();
  endtask

  // ----------------------------------------------------------------------
  // sequence
  // ----------------------------------------------------------------------
  initial
  begin
    rst_n      = 1'b0;
    apb_req    = '0;
    evt_data   = '0;
    evt_vld    = 1'b0;
    tx_rdy     = '1;
    held_vld   = '0;
    lfsr_state = 32'd43;
    err_value  = 0;
    err_other  = 0;
    cycles     = 0;
    for (int i = 0; i < `DVS_NUM_ENTRIES; i++)
    begin
      tbl_key[i]   = '0;
      tbl_mask[i]  = '0;
      tbl_route[i] = '0;
    end
    repeat (4) @(posedge pl_clk0_buf_int);
    #10;
    rst_n = 1'b1;
    test_default_route();
    test_registers();
    test_programmed();
    test_backpressure();
    test_stop();
    if (pending_count() != 0)
    begin
      $display("%0d expected packets never arrived", pending_count());
      err_other++;
    end
    $display("errors: %0d value mismatches, %0d other failures", err_value, err_other);
    if (err_value + err_other == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

endmodule

// ==== all.f ====
+incdir+common
+incdir+verification
common/dvs_hssl_pkg.sv
reg_bank/hssl_reg_bank.sv
pkt_path/pkt_assembler.sv
pkt_path/pkt_router.sv
src/dvs_hssl_top.sv
verification/tb_dvs_hssl_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the testbench with Verilator, then scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -f all.f --top-module tb_dvs_hssl_top -o tb_sim > sim.log 2>&1 \
  && ./obj_dir/tb_sim >> sim.log 2>&1 \
  || echo "build or run failed" >> sim.log
grep -q "TEST FAIL" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q "TEST PASS" sim.log || { echo "no pass result in sim.log"; exit 1; }
echo "simulation passed"
